// ==== verilog/aes_pkg.sv ====
// shared AES-128 definitions
// widths, request and control structs, round constants
// GF(2^8) helpers and the S-box table function
package aes_pkg;

	////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////

	// one state byte
	typedef logic [7:0] byte_t;
	// one column or one key word
	typedef logic [31:0] word_t;
	// full state, column-major, w[0] in the top bits
	typedef logic [127:0] block_t;
	// round number 0 to 10
	typedef logic [3:0] round_t;

	// fixed by AES-128 (Nk = 4, Nb = 4)
	localparam int NUM_ROUNDS = 10;
	// one S-box cycle plus one update cycle
	localparam int ROUND_CYCLES = 2;
	// x^8 + x^4 + x^3 + x + 1 with the x^8 term dropped
	localparam byte_t AES_POLY = 8'h1b;

	// request on the input handshake
	typedef struct packed {
		block_t key;
		block_t plaintext;
	} aes_req_t;

	// sequencer to execute stage
	typedef struct packed {
		logic load;
		logic step;
		logic last;
		round_t round;
	} aes_ctrl_t;

	////////////////////////////////////////////////////////////
	// GF(2^8) arithmetic
	////////////////////////////////////////////////////////////

	// multiply by x, reduce when bit 7 falls out
	function automatic byte_t xtime(input byte_t b);
		return {b[6:0], 1'b0} ^ (b[7] ? AES_POLY : 8'h00);
	endfunction

	// shift-and-add product
	function automatic byte_t gf_mul(input byte_t a, input byte_t b);
		byte_t p;
		byte_t x;
		p = '0;
		x = a;
		for (int i = 0; i < 8; i++) begin
			if (b[i])
				p = p ^ x;
			x = xtime(x);
		end
		return p;
	endfunction

	// multiplicative inverse by search, then the affine transform
	// only used to fill the ROM at elaboration
	function automatic byte_t sbox_value(input byte_t a);
		byte_t inv;
		inv = '0;
		for (int i = 1; i < 256; i++) begin
			if (gf_mul(a, byte_t'(i)) == 8'h01)
				inv = byte_t'(i);
		end
		// b ^ rotl1 ^ rotl2 ^ rotl3 ^ rotl4 ^ 0x63
		return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
			^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
	endfunction

	// Rcon[r] = {x^(r-1), 00, 00, 00}
	function automatic word_t rcon_word(input round_t r);
		byte_t rc;
		rc = 8'h01;
		// fixed bound so the loop unrolls
		for (int i = 2; i <= NUM_ROUNDS; i++) begin
			if (i <= int'(r))
				rc = xtime(rc);
		end
		return {rc, 24'h000000};
	endfunction

endpackage

// ==== verilog/aes_sbox.sv ====
// synchronous byte substitution ROM
// one registered lookup per clock
module aes_sbox
	import aes_pkg::*;
(
	input  logic  clk,
	input  byte_t a,
	output byte_t y
);

	// 256 entries, filled from the package function
	byte_t rom [0:255];

	initial begin
		for (int i = 0; i < 256; i++)
			rom[i] = sbox_value(byte_t'(i));
	end

	// registered read, maps onto block RAM
	// samples every edge, stalls just re-read the same address
	always_ff @(posedge clk) begin
		y <= rom[a];
	end

endmodule

// ==== verilog/aes_sequencer.sv ====
// round sequencer
// request acceptance, IDLE/SUB/MIX state machine, round counter
module aes_sequencer
	import aes_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      in_valid,
	output logic      in_ready,
	output aes_ctrl_t ctrl,
	output logic      done_valid,
	input  logic      done_ready
);

	// SUB: S-boxes register, MIX: state and key update
	typedef enum logic [1:0] {
		IDLE,
		SUB,
		MIX
	} seq_state_t;

	seq_state_t state_q;
	seq_state_t state_d;
	round_t     round_q;
	logic       accept;
	logic       last;
	logic       step;

	////////////////////////////////////////////////////////////
	// control decode
	////////////////////////////////////////////////////////////

	// only take a new block when nothing is in the rounds
	assign in_ready = (state_q == IDLE);
	assign accept   = in_valid && in_ready;
	assign last     = (round_q == round_t'(NUM_ROUNDS));

	// final round waits until the result buffer can take it
	assign step       = (state_q == MIX) && (!last || done_ready);
	assign done_valid = step && last;

	assign ctrl.load  = accept;
	assign ctrl.step  = step;
	assign ctrl.last  = last;
	assign ctrl.round = round_q;

	////////////////////////////////////////////////////////////
	// state machine
	////////////////////////////////////////////////////////////

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: if (accept) state_d = SUB;
			SUB:  state_d = MIX;
			// stall here on back-pressure in round 10
			MIX:  if (step) state_d = last ? IDLE : SUB;
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= IDLE;
			round_q <= '0;
		end else begin
			state_q <= state_d;
			// rounds count 1 to NUM_ROUNDS
			if (accept)
				round_q <= round_t'(1);
			else if (step && !last)
				round_q <= round_q + round_t'(1);
		end
	end

endmodule

// ==== verilog/aes_key_expand.sv ====
// key expansion
// round key register, RotWord/SubWord/Rcon and the XOR chain
module aes_key_expand
	import aes_pkg::*;
(
	input  logic      clk,
	input  block_t    key,
	input  aes_ctrl_t ctrl,
	output block_t    round_key
);

	// key of the current round, w[0] in [127:96]
	block_t key_q;
	// RotWord of w[3]
	word_t  rot_word;
	// registered SubWord, valid in the MIX cycle
	word_t  sub_word;
	// SubWord with Rcon applied
	word_t  temp;
	block_t next_key;

	// rotate bytes left by one
	assign rot_word = {key_q[23:0], key_q[31:24]};

	////////////////////////////////////////////////////////////
	// SubWord, one S-box per byte
	////////////////////////////////////////////////////////////

	for (genvar i = 0; i < 4; i++) begin : g_sub_word
		aes_sbox u_sbox (
			.clk (clk),
			.a   (rot_word[8*i +: 8]),
			.y   (sub_word[8*i +: 8])
		);
	end

	assign temp = sub_word ^ rcon_word(ctrl.round);

	// each word chains off the one just built
	always_comb begin
		next_key[127:96] = key_q[127:96] ^ temp;
		next_key[95:64]  = key_q[95:64] ^ next_key[127:96];
		next_key[63:32]  = key_q[63:32] ^ next_key[95:64];
		next_key[31:0]   = key_q[31:0] ^ next_key[63:32];
	end

	// round 0 key on load, expanded key otherwise
	// same value the register takes, so the round adds it directly
	assign round_key = ctrl.load ? key : next_key;

	always_ff @(posedge clk) begin
		if (ctrl.load || ctrl.step)
			key_q <= round_key;
	end

endmodule

// ==== verilog/aes_round.sv ====
// cipher state path
// state register, AddRoundKey, SubBytes, ShiftRows, MixColumns
module aes_round
	import aes_pkg::*;
(
	input  logic      clk,
	input  block_t    plaintext,
	input  block_t    round_key,
	input  aes_ctrl_t ctrl,
	output block_t    next_state
);

	// state after the previous AddRoundKey
	block_t state_q;
	// SubBytes result, one cycle behind state_q
	block_t sub_q;
	block_t shifted;
	block_t mixed;

	////////////////////////////////////////////////////////////
	// MixColumns, lightweight xtime form
	////////////////////////////////////////////////////////////

	// y_i = a_i ^ (a0^a1^a2^a3) ^ xtime(a_i ^ a_(i+1))
	function automatic word_t mix_column(input word_t col);
		byte_t a0;
		byte_t a1;
		byte_t a2;
		byte_t a3;
		byte_t tmp;
		a0  = col[31:24];
		a1  = col[23:16];
		a2  = col[15:8];
		a3  = col[7:0];
		tmp = a0 ^ a1 ^ a2 ^ a3;
		return {a0 ^ tmp ^ xtime(a0 ^ a1),
			a1 ^ tmp ^ xtime(a1 ^ a2),
			a2 ^ tmp ^ xtime(a2 ^ a3),
			a3 ^ tmp ^ xtime(a3 ^ a0)};
	endfunction

	////////////////////////////////////////////////////////////
	// SubBytes
	////////////////////////////////////////////////////////////

	// byte order does not matter here, every byte gets its own ROM
	for (genvar i = 0; i < 16; i++) begin : g_sub_bytes
		aes_sbox u_sbox (
			.clk (clk),
			.a   (state_q[8*i +: 8]),
			.y   (sub_q[8*i +: 8])
		);
	end

	// byte (r, c) lives at bits [127 - 8*(4c + r) -: 8]
	// row r rotates left by r columns
	always_comb begin
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				shifted[127 - 8*(4*c + r) -: 8] =
					sub_q[127 - 8*(4*((c + r) % 4) + r) -: 8];
			end
		end
	end

	// columns are independent 32-bit words
	always_comb begin
		for (int c = 0; c < 4; c++)
			mixed[32*c +: 32] = mix_column(shifted[32*c +: 32]);
	end

	// final round has no MixColumns
	assign next_state = (ctrl.last ? shifted : mixed) ^ round_key;

	////////////////////////////////////////////////////////////
	// state register
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		// round 0 is just AddRoundKey with the cipher key
		if (ctrl.load)
			state_q <= plaintext ^ round_key;
		else if (ctrl.step)
			state_q <= next_state;
	end

endmodule

// ==== verilog/aes_result.sv ====
// one-entry ciphertext buffer
// holds a finished block until the output side takes it
module aes_result
	import aes_pkg::*;
(
	input  logic   clk,
	input  logic   reset,
	input  logic   done_valid,
	output logic   done_ready,
	input  block_t next_state,
	output logic   out_valid,
	input  logic   out_ready,
	output block_t out_ciphertext
);

	logic   full_q;
	block_t data_q;
	logic   fill;

	// room when empty, or when the held block leaves on this edge
	assign done_ready = !full_q || out_ready;
	assign fill       = done_valid && done_ready;

	always_ff @(posedge clk) begin
		if (reset)
			full_q <= 1'b0;
		else if (fill)
			full_q <= 1'b1;
		// drain with nothing coming in
		else if (out_ready)
			full_q <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (fill)
			data_q <= next_state;
	end

	assign out_valid      = full_q;
	assign out_ciphertext = data_q;

endmodule

// ==== verilog/aes_top.sv ====
// AES-128 encryption engine
// valid/ready request in, valid/ready ciphertext out
// sequencer, state path, key expansion, result buffer
module aes_top
	import aes_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     in_valid,
	output logic     in_ready,
	input  aes_req_t in_req,
	output logic     out_valid,
	input  logic     out_ready,
	output block_t   out_ciphertext
);

	aes_ctrl_t ctrl;
	logic      done_valid;
	logic      done_ready;
	block_t    round_key;
	// last-round value goes straight into the buffer
	block_t    next_state;

	////////////////////////////////////////////////////////////
	// decode
	////////////////////////////////////////////////////////////

	aes_sequencer u_sequencer (
		.clk        (clk),
		.reset      (reset),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.ctrl       (ctrl),
		.done_valid (done_valid),
		.done_ready (done_ready)
	);

	////////////////////////////////////////////////////////////
	// execute
	////////////////////////////////////////////////////////////

	aes_key_expand u_key_expand (
		.clk       (clk),
		.key       (in_req.key),
		.ctrl      (ctrl),
		.round_key (round_key)
	);

	aes_round u_round (
		.clk        (clk),
		.plaintext  (in_req.plaintext),
		.round_key  (round_key),
		.ctrl       (ctrl),
		.next_state (next_state)
	);

	// result
	aes_result u_result (
		.clk            (clk),
		.reset          (reset),
		.done_valid     (done_valid),
		.done_ready     (done_ready),
		.next_state     (next_state),
		.out_valid      (out_valid),
		.out_ready      (out_ready),
		.out_ciphertext (out_ciphertext)
	);

endmodule

// ==== sim/tb_clk_gen.sv ====
// testbench clock and reset
// 8 ns period, reset high for the first 2 rising edges
module tb_clk_gen (
	output logic clk,
	output logic reset
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// released 1 ns after the second edge, same offset as the other inputs
	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
	end
endmodule

// ==== sim/aes_model.svh ====
// reference AES-128 encryption for the testbench
// table-free S-box, matrix-form MixColumns, full key schedule
`ifndef AES_MODEL_SVH
`define AES_MODEL_SVH

// GF(2^8) product, Horner form over the bits of b
function automatic byte_t model_mul(input byte_t a, input byte_t b);
	byte_t p;
	p = 8'h00;
	for (int i = 7; i >= 0; i--) begin
		p = {p[6:0], 1'b0} ^ (p[7] ? 8'h1b : 8'h00);
		if (b[i])
			p = p ^ a;
	end
	return p;
endfunction

// inverse as a^254, zero maps to zero
function automatic byte_t model_sbox(input byte_t a);
	byte_t inv;
	byte_t sq;
	byte_t s;
	inv = 8'h01;
	sq  = a;
	for (int i = 1; i < 8; i++) begin
		sq  = model_mul(sq, sq);
		inv = model_mul(inv, sq);
	end
	// affine map, bit i takes bits i, i+4 .. i+7
	for (int i = 0; i < 8; i++)
		s[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8] ^ inv[(i + 6) % 8]
			^ inv[(i + 7) % 8];
	return s ^ 8'h63;
endfunction

function automatic block_t model_encrypt(input block_t key, input block_t pt);
	word_t  w [0:43];
	byte_t  s [0:15];
	byte_t  t [0:15];
	word_t  tmp;
	byte_t  rc;
	block_t ct;
	rc = 8'h01;
	// all 44 words up front
	for (int i = 0; i < 44; i++) begin
		if (i < 4) begin
			w[i] = key[127 - 32*i -: 32];
		end else begin
			tmp = w[i - 1];
			if (i % 4 == 0) begin
				tmp = {model_sbox(tmp[23:16]), model_sbox(tmp[15:8]),
					model_sbox(tmp[7:0]), model_sbox(tmp[31:24])} ^ {rc, 24'h000000};
				rc = model_mul(rc, 8'h02);
			end
			w[i] = w[i - 4] ^ tmp;
		end
	end
	// byte i is row i % 4 of column i / 4
	for (int i = 0; i < 16; i++)
		s[i] = pt[127 - 8*i -: 8] ^ w[i / 4][31 - 8*(i % 4) -: 8];
	for (int r = 1; r <= 10; r++) begin
		// SubBytes and ShiftRows, row j of column c comes from column c + j
		for (int i = 0; i < 16; i++)
			t[i] = model_sbox(s[4*((i / 4 + i % 4) % 4) + i % 4]);
		for (int i = 0; i < 16; i++) begin
			if (r == 10)
				s[i] = t[i];
			else
				s[i] = model_mul(t[i], 8'h02) ^ model_mul(t[4*(i / 4) + (i + 1) % 4], 8'h03)
					^ t[4*(i / 4) + (i + 2) % 4] ^ t[4*(i / 4) + (i + 3) % 4];
			s[i] = s[i] ^ w[4*r + i / 4][31 - 8*(i % 4) -: 8];
		end
	end
	for (int i = 0; i < 16; i++)
		ct[127 - 8*i -: 8] = s[i];
	return ct;
endfunction

`endif

// ==== sim/tb_aes.sv ====
// testbench top for the AES-128 engine
// LFSR stimulus, scoreboard against the reference model
// reset, known answer, latency, random traffic and back-pressure tests
module tb_aes
	import aes_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	// known answer, latency, random, back-pressure
	localparam int NUM_BLOCKS = 1 + 50 + 200 + 2;
	localparam int TIMEOUT_CYCLES = NUM_BLOCKS * 64 + 100;
	// accept edge to out_valid with no back-pressure
	localparam int LATENCY = 20;

	logic     clk;
	logic     reset;
	logic     in_valid;
	logic     in_ready;
	aes_req_t in_req;
	logic     out_valid;
	logic     out_ready;
	block_t   out_ciphertext;

	logic [31:0] lfsr = 32'hbe5b;
	// expected ciphertexts in request order
	block_t      exp_q [$];
	int          cycles = 0;
	logic        hold_check = 1'b0;
	block_t      held_ct;

	`include "aes_model.svh"

	tb_clk_gen u_clk_gen (
		.clk   (clk),
		.reset (reset)
	);

	aes_top u_dut (
		.clk            (clk),
		.reset          (reset),
		.in_valid       (in_valid),
		.in_ready       (in_ready),
		.in_req         (in_req),
		.out_valid      (out_valid),
		.out_ready      (out_ready),
		.out_ciphertext (out_ciphertext)
	);

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one LFSR step per bit
	task automatic take_bits(input int n, output block_t v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[126:0], lfsr[0]};
		end
	endtask

	task automatic fail_with(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input block_t exp, input block_t act);
		assert (act === exp) else
			fail_with($sformatf("[FAIL] %0t %s expected %0h got %0h", $time, name, exp, act));
	endtask

	// starts 1 ns after an edge and returns 1 ns after the accept edge
	task automatic send(input block_t key, input block_t pt);
		in_req.key       = key;
		in_req.plaintext = pt;
		in_valid         = 1'b1;
		do
			@(negedge clk);
		while (!in_ready);
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic wait_out();
		do
			@(negedge clk);
		while (!out_valid);
	endtask

	////////////////////////////////////////////////////////////
	// tests
	////////////////////////////////////////////////////////////

	task automatic latency_test(input int n);
		block_t k;
		block_t p;
		int     wait_cycles;
		for (int b = 0; b < n; b++) begin
			take_bits(128, k);
			take_bits(128, p);
			send(k, p);
			// edges counted after the accept edge
			wait_cycles = 0;
			@(negedge clk);
			while (!out_valid) begin
				assert (!in_ready) else fail_with("in_ready high while a block is in the rounds");
				@(negedge clk);
				wait_cycles++;
			end
			check_value("latency", LATENCY, wait_cycles);
			@(posedge clk);
			#1;
		end
	endtask

	// random in_valid gaps and random out_ready with one decision per cycle
	task automatic random_test(input int n);
		block_t r;
		logic   go;
		int     sent;
		sent = 0;
		while (sent < n || exp_q.size() > 0) begin
			@(negedge clk);
			go = in_valid && in_ready;
			@(posedge clk);
			#1;
			if (go) begin
				sent++;
				in_valid = 1'b0;
			end
			take_bits(2, r);
			if (!in_valid && sent < n && r[1:0] != 2'b00) begin
				take_bits(128, r);
				in_req.key = r;
				take_bits(128, r);
				in_req.plaintext = r;
				in_valid = 1'b1;
			end
			take_bits(1, r);
			out_ready = r[0];
		end
	endtask

	task automatic backpressure_test();
		block_t k;
		block_t p;
		out_ready = 1'b0;
		// first block parks in the result buffer
		take_bits(128, k);
		take_bits(128, p);
		send(k, p);
		wait_out();
		@(posedge clk);
		#1;
		// second block goes in behind it and stalls in round 10
		take_bits(128, k);
		take_bits(128, p);
		send(k, p);
		repeat (30) @(posedge clk);
		#1;
		assert (out_valid && !in_ready) else
			fail_with("second block not held behind the waiting result");
		out_ready = 1'b1;
		while (exp_q.size() > 0) begin
			@(posedge clk);
			#1;
		end
	endtask

	////////////////////////////////////////////////////////////
	// monitor sampled on the falling edge
	////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES)
			fail_with($sformatf("timeout, run still going after %0d cycles", cycles));
		if (!reset) begin
			// a refused block must stay put
			if (hold_check) begin
				assert (out_valid) else fail_with("out_valid dropped before the block was taken");
				check_value("out_ciphertext", held_ct, out_ciphertext);
			end
			if (in_valid && in_ready)
				exp_q.push_back(model_encrypt(in_req.key, in_req.plaintext));
			if (out_valid && out_ready) begin
				assert (exp_q.size() > 0) else fail_with("ciphertext out with no request pending");
				check_value("out_ciphertext", exp_q.pop_front(), out_ciphertext);
			end
			hold_check = out_valid && !out_ready;
			held_ct    = out_ciphertext;
		end
	end

	initial begin
		in_valid  = 1'b0;
		out_ready = 1'b0;
		in_req    = '0;
		@(negedge reset);
		@(negedge clk);
		check_value("in_ready", 1, in_ready);
		check_value("out_valid", 0, out_valid);
		@(posedge clk);
		#1;
		// FIPS-197 appendix vector
		out_ready = 1'b1;
		send(128'h000102030405060708090a0b0c0d0e0f, 128'h00112233445566778899aabbccddeeff);
		wait_out();
		check_value("out_ciphertext", 128'h69c4e0d86a7b0430d8cdb78070b4c55a, out_ciphertext);
		@(posedge clk);
		#1;
		latency_test(50);
		random_test(200);
		backpressure_test();
		// engine empty once the last block has left
		@(negedge clk);
		assert (!out_valid) else fail_with("out_valid high after the last block was taken");
		assert (in_ready) else fail_with("in_ready low with no block in the engine");
		$display("Finished with no errors");
		$finish;
	end
endmodule

// ==== Bender.yml ====
package:
  name: aes128_engine

sources:
  # RTL, package first
  - verilog/aes_pkg.sv
  - verilog/aes_sbox.sv
  - verilog/aes_sequencer.sv
  - verilog/aes_key_expand.sv
  - verilog/aes_round.sv
  - verilog/aes_result.sv
  - verilog/aes_top.sv
  # testbench
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_clk_gen.sv
      - sim/tb_aes.sv

// ==== sources.f ====
+incdir+sim
verilog/aes_pkg.sv
verilog/aes_sbox.sv
verilog/aes_sequencer.sv
verilog/aes_key_expand.sv
verilog/aes_round.sv
verilog/aes_result.sv
verilog/aes_top.sv
sim/tb_clk_gen.sv
sim/tb_aes.sv
